// ==== verilog/ppu_pkg.sv ====
// --------------------------------------
// PPU shared definitions
// Register map, data widths and video timing
// --------------------------------------

package ppu_pkg;

    // Register indices as seen on paddr
    typedef enum logic [5:0] {
        INIDISP = 6'h00,
        VMAIN   = 6'h15,
        VMADDL  = 6'h16,
        VMADDH  = 6'h17,
        VMDATAL = 6'h18,
        VMDATAH = 6'h19,
        M7A     = 6'h1B,
        M7B     = 6'h1C,
        CGADD   = 6'h21,
        CGDATA  = 6'h22,
        MPYL    = 6'h34,
        MPYM    = 6'h35,
        MPYH    = 6'h36,
        SLHV    = 6'h37,
        RDVRAML = 6'h39,
        RDVRAMH = 6'h3A,
        RDCGRAM = 6'h3B,
        OPHCT   = 6'h3C,
        OPVCT   = 6'h3D,
        STAT78  = 6'h3F
    } reg_index_t;

    typedef logic [14:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;
    typedef logic [14:0] color_t;
    typedef logic [7:0]  cgram_addr_t;
    typedef logic [8:0]  counter_t;

    // Video timing
    localparam int H_TOTAL      = 341;
    localparam int V_TOTAL      = 262;
    localparam int H_VISIBLE    = 256;
    localparam int V_VISIBLE    = 224;
    localparam int FETCH_PERIOD = 8;

endpackage

// ==== verilog/ppu_regs.sv ====
// --------------------------------------
// PPU register block
// APB slave with register decode, forced blank,
// mode-7 multiplier and H/V counter latch
// --------------------------------------

`timescale 1ns/1ps

module ppu_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  ppu_pkg::reg_index_t paddr,
    input  logic [7:0]          pwdata,
    input  logic                vram_done,
    input  ppu_pkg::vram_word_t prefetch,
    input  logic [7:0]          cgram_rdata,
    input  ppu_pkg::counter_t   h_ctr,
    input  ppu_pkg::counter_t   v_ctr,
    output logic [7:0]          prdata,
    output logic                pready,
    output logic                fblank,
    output logic [4:0]          vmain,
    output logic                vram_op,
    output logic                cg_strobe,
    output ppu_pkg::reg_index_t reg_index,
    output logic [7:0]          wdata
);
    import ppu_pkg::*;

    logic        access;
    logic        vram_acc;
    logic        done;
    logic        wr_done;
    logic        rd_done;
    logic [7:0]  m7_old;
    logic [15:0] m7_a;
    logic [7:0]  m7_b;
    logic [23:0] product;
    counter_t    h_latch;
    counter_t    v_latch;
    logic        hv_flag;
    logic        h_tgl;
    logic        v_tgl;

    // ----------------------------------------
    // APB handshake
    // ----------------------------------------

    // Index and data captured in the setup phase
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_index <= INIDISP;
        end else if (psel && !penable) begin
            reg_index <= paddr;
        end
    end

    always_ff @(posedge clk) begin
        if (psel && !penable) begin
            wdata <= pwdata;
        end
    end

    // Accesses that need a VRAM cycle
    always_comb begin
        if (pwrite) begin
            vram_acc = reg_index inside {VMADDL, VMADDH, VMDATAL, VMDATAH};
        end else begin
            vram_acc = (reg_index == (vmain[4] ? RDVRAMH : RDVRAML));
        end
    end

    assign access  = psel && penable;
    assign pready  = access && (!vram_acc || vram_done);
    assign vram_op = access && vram_acc;
    assign done    = access && pready;
    assign wr_done = done && pwrite;
    assign rd_done = done && !pwrite;

    assign cg_strobe = pwrite ? (wr_done && (reg_index inside {CGADD, CGDATA}))
                              : (rd_done && (reg_index == RDCGRAM));

    // ----------------------------------------
    // Write registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            fblank <= 1'b1;
            vmain  <= 5'h00;
            m7_a   <= 16'h0000;
            m7_b   <= 8'h00;
        end else if (wr_done) begin
            case (reg_index)
                INIDISP: fblank <= wdata[7];
                VMAIN:   vmain <= {wdata[7], wdata[3:0]};
                M7A:     m7_a <= {wdata, m7_old};
                M7B:     m7_b <= wdata;
                default: ;
            endcase
        end
    end

    // Low byte of the M7A pair
    always_ff @(posedge clk) begin
        if (wr_done && reg_index == M7A) begin
            m7_old <= wdata;
        end
    end

    assign product = $signed(m7_a) * $signed(m7_b);

    // H/V latch and its read toggles
    always_ff @(posedge clk) begin
        if (reset) begin
            h_latch <= '0;
            v_latch <= '0;
            hv_flag <= 1'b0;
            h_tgl   <= 1'b0;
            v_tgl   <= 1'b0;
        end else if (done) begin
            case (reg_index)
                SLHV: begin
                    h_latch <= h_ctr;
                    v_latch <= v_ctr;
                    hv_flag <= 1'b1;
                end
                OPHCT:  h_tgl <= ~h_tgl;
                OPVCT:  v_tgl <= ~v_tgl;
                STAT78: begin
                    hv_flag <= 1'b0;
                    h_tgl   <= 1'b0;
                    v_tgl   <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Read data
    // ----------------------------------------

    always_comb begin
        case (reg_index)
            RDVRAML: prdata = prefetch[7:0];
            RDVRAMH: prdata = prefetch[15:8];
            RDCGRAM: prdata = cgram_rdata;
            MPYL:    prdata = product[7:0];
            MPYM:    prdata = product[15:8];
            MPYH:    prdata = product[23:16];
            OPHCT:   prdata = h_tgl ? {7'h00, h_latch[8]} : h_latch[7:0];
            OPVCT:   prdata = v_tgl ? {7'h00, v_latch[8]} : v_latch[7:0];
            STAT78:  prdata = {1'b0, hv_flag, 6'h00};
            default: prdata = 8'h00;
        endcase
    end

endmodule

// ==== verilog/vram_port.sv ====
// --------------------------------------
// VRAM CPU port
// Address register, increment, remap and read prefetch
// --------------------------------------

`timescale 1ns/1ps

module vram_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                vram_op,
    input  ppu_pkg::reg_index_t reg_index,
    input  logic [7:0]          wdata,
    input  logic [4:0]          vmain,
    input  logic                cpu_gnt,
    input  ppu_pkg::vram_word_t rdata,
    output logic                cpu_req,
    output ppu_pkg::vram_addr_t cpu_addr,
    output logic [1:0]          cpu_we,
    output ppu_pkg::vram_word_t cpu_wdata,
    output logic                vram_done,
    output ppu_pkg::vram_word_t prefetch
);
    import ppu_pkg::*;

    vram_addr_t addr;
    vram_addr_t access_addr;
    vram_addr_t step;
    logic       inc_hit;
    logic       addr_load;

    // VMADD writes use the new address in the same cycle
    always_comb begin
        case (reg_index)
            VMADDL:  access_addr = {addr[14:8], wdata};
            VMADDH:  access_addr = {wdata[6:0], addr[7:0]};
            default: access_addr = addr;
        endcase
    end

    // Remap rotates the low 8, 9 or 10 bits left by 3
    always_comb begin
        case (vmain[3:2])
            2'd1:    cpu_addr = {access_addr[14:8], access_addr[4:0], access_addr[7:5]};
            2'd2:    cpu_addr = {access_addr[14:9], access_addr[5:0], access_addr[8:6]};
            2'd3:    cpu_addr = {access_addr[14:10], access_addr[6:0], access_addr[9:7]};
            default: cpu_addr = access_addr;
        endcase
    end

    always_comb begin
        case (vmain[1:0])
            2'd0:    step = 15'd1;
            2'd1:    step = 15'd32;
            default: step = 15'd128;
        endcase
    end

    assign addr_load = reg_index inside {VMADDL, VMADDH};
    assign inc_hit = vmain[4] ? (reg_index inside {VMDATAH, RDVRAMH})
                              : (reg_index inside {VMDATAL, RDVRAML});

    // One request per access, dropped once granted
    assign cpu_req   = vram_op && !vram_done;
    assign cpu_wdata = {wdata, wdata};

    always_comb begin
        cpu_we = 2'b00;
        if (cpu_req && reg_index == VMDATAL) begin
            cpu_we = 2'b01;
        end else if (cpu_req && reg_index == VMDATAH) begin
            cpu_we = 2'b10;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            addr      <= '0;
            vram_done <= 1'b0;
        end else begin
            vram_done <= cpu_gnt;
            if (cpu_gnt && addr_load) begin
                addr <= access_addr;
            end else if (cpu_gnt && inc_hit) begin
                addr <= addr + step;
            end
        end
    end

    // Memory word of the pre-increment address
    always_ff @(posedge clk) begin
        if (vram_done && (reg_index inside {VMADDL, VMADDH, RDVRAML, RDVRAMH})) begin
            prefetch <= rdata;
        end
    end

endmodule

// ==== verilog/vram_bank.sv ====
// --------------------------------------
// VRAM bank
// 32K words with a fixed-priority arbiter,
// display fetch ahead of the CPU port
// --------------------------------------

`timescale 1ns/1ps

module vram_bank (
    input  logic                clk,
    input  logic                reset,
    input  logic                disp_req,
    input  ppu_pkg::vram_addr_t disp_addr,
    input  logic                cpu_req,
    input  ppu_pkg::vram_addr_t cpu_addr,
    input  logic [1:0]          cpu_we,
    input  ppu_pkg::vram_word_t cpu_wdata,
    output logic                cpu_gnt,
    output ppu_pkg::vram_word_t rdata
);
    import ppu_pkg::*;

    vram_word_t mem [0:32767];
    vram_addr_t mem_addr;

    // Display fetch always wins
    assign cpu_gnt  = cpu_req && !disp_req;
    assign mem_addr = disp_req ? disp_addr : cpu_addr;

    always_ff @(posedge clk) begin
        if (cpu_gnt) begin
            if (cpu_we[0]) begin
                mem[cpu_addr][7:0] <= cpu_wdata[7:0];
            end
            if (cpu_we[1]) begin
                mem[cpu_addr][15:8] <= cpu_wdata[15:8];
            end
        end
    end

    // Synchronous read of the selected address
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            rdata <= mem[mem_addr];
        end
    end

endmodule

// ==== verilog/line_fetch.sv ====
// --------------------------------------
// Display line fetch
// Dot and line counters, one VRAM word per 8 dots
// --------------------------------------

`timescale 1ns/1ps

module line_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                fblank,
    input  ppu_pkg::vram_word_t rdata,
    output ppu_pkg::counter_t   h_ctr,
    output ppu_pkg::counter_t   v_ctr,
    output logic                disp_req,
    output ppu_pkg::vram_addr_t disp_addr,
    output logic                fetch_valid,
    output ppu_pkg::vram_addr_t fetch_addr,
    output ppu_pkg::vram_word_t fetch_word
);
    import ppu_pkg::*;

    logic visible;

    always_ff @(posedge clk) begin
        if (reset) begin
            h_ctr <= '0;
            v_ctr <= '0;
        end else if (h_ctr == counter_t'(H_TOTAL - 1)) begin
            h_ctr <= '0;
            if (v_ctr == counter_t'(V_TOTAL - 1)) begin
                v_ctr <= '0;
            end else begin
                v_ctr <= v_ctr + 1'b1;
            end
        end else begin
            h_ctr <= h_ctr + 1'b1;
        end
    end

    assign visible  = (h_ctr < H_VISIBLE) && (v_ctr < V_VISIBLE);
    assign disp_req = visible && !fblank && ((h_ctr % FETCH_PERIOD) == 0);

    // 32 words per line
    assign disp_addr = vram_addr_t'({v_ctr, 5'b00000})
                     + vram_addr_t'(h_ctr / FETCH_PERIOD);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= disp_req;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_req) begin
            fetch_addr <= disp_addr;
        end
    end

    // Bank output is already registered
    assign fetch_word = rdata;

endmodule

// ==== verilog/cgram_port.sv ====
// --------------------------------------
// CGRAM palette port
// 256 colors, byte-pair access with auto-increment
// --------------------------------------

`timescale 1ns/1ps

module cgram_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                cg_strobe,
    input  ppu_pkg::reg_index_t reg_index,
    input  logic [7:0]          wdata,
    output logic [7:0]          cgram_rdata
);
    import ppu_pkg::*;

    color_t      mem [0:255];
    color_t      q;
    cgram_addr_t addr;
    logic        tgl;
    logic [7:0]  low_buf;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
            tgl  <= 1'b0;
        end else if (cg_strobe) begin
            case (reg_index)
                CGADD: begin
                    addr <= wdata;
                    tgl  <= 1'b0;
                end
                CGDATA, RDCGRAM: begin
                    tgl <= ~tgl;
                    // Next color after the high byte
                    if (tgl) begin
                        addr <= addr + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cg_strobe && reg_index == CGDATA) begin
            if (tgl) begin
                mem[addr] <= {wdata[6:0], low_buf};
            end else begin
                low_buf <= wdata;
            end
        end
        q <= mem[addr];
    end

    assign cgram_rdata = tgl ? {1'b0, q[14:8]} : q[7:0];

endmodule

// ==== verilog/ppu_top.sv ====
// --------------------------------------
// PPU top level
// Register block, VRAM peers with arbiter, CGRAM
// --------------------------------------

`timescale 1ns/1ps

module ppu_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [5:0]          paddr,
    input  logic [7:0]          pwdata,
    output logic [7:0]          prdata,
    output logic                pready,
    output ppu_pkg::counter_t   h_ctr,
    output ppu_pkg::counter_t   v_ctr,
    output logic                fetch_valid,
    output ppu_pkg::vram_addr_t fetch_addr,
    output ppu_pkg::vram_word_t fetch_word
);
    import ppu_pkg::*;

    logic       fblank;
    logic [4:0] vmain;
    logic       vram_op;
    logic       vram_done;
    logic       cg_strobe;
    reg_index_t reg_index;
    logic [7:0] wdata;
    logic [7:0] cgram_rdata;
    vram_word_t prefetch;
    vram_word_t rdata;
    logic       cpu_req;
    logic       cpu_gnt;
    vram_addr_t cpu_addr;
    logic [1:0] cpu_we;
    vram_word_t cpu_wdata;
    logic       disp_req;
    vram_addr_t disp_addr;

    ppu_regs ppu_regs_i (
        .clk, .reset, .psel, .penable, .pwrite,
        .paddr(reg_index_t'(paddr)),
        .pwdata, .vram_done, .prefetch, .cgram_rdata, .h_ctr, .v_ctr,
        .prdata, .pready, .fblank, .vmain, .vram_op, .cg_strobe, .reg_index, .wdata
    );

    vram_port vram_port_i (
        .clk, .reset, .vram_op, .reg_index, .wdata, .vmain, .cpu_gnt, .rdata,
        .cpu_req, .cpu_addr, .cpu_we, .cpu_wdata, .vram_done, .prefetch
    );

    vram_bank vram_bank_i (
        .clk, .reset, .disp_req, .disp_addr,
        .cpu_req, .cpu_addr, .cpu_we, .cpu_wdata, .cpu_gnt, .rdata
    );

    line_fetch line_fetch_i (
        .clk, .reset, .fblank, .rdata,
        .h_ctr, .v_ctr, .disp_req, .disp_addr, .fetch_valid, .fetch_addr, .fetch_word
    );

    cgram_port cgram_port_i (
        .clk, .reset, .cg_strobe, .reg_index, .wdata, .cgram_rdata
    );

endmodule

// ==== tests/ppu_assert.sv ====
// ----------------------------------------
// PPU bus and fetch assertions
// Bound to the top level
// ----------------------------------------

`timescale 1ns/1ps

module ppu_assert (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic fetch_valid
);

    logic [2:0] stall_cnt;

    // Access phase cycles spent waiting on pready
    always_ff @(posedge clk) begin
        if (reset) begin
            stall_cnt <= '0;
        end else if (psel && penable && !pready) begin
            stall_cnt <= stall_cnt + 1'b1;
        end else begin
            stall_cnt <= '0;
        end
    end

    a_ready_soon: assert property (@(posedge clk) disable iff (reset) stall_cnt < 3'd4)
        else $error("pready low for more than 4 cycles of an access phase");

    a_fetch_pulse: assert property (@(posedge clk) disable iff (reset)
        fetch_valid |=> !fetch_valid)
        else $error("fetch_valid high for 2 consecutive cycles");

    a_ready_idle: assert property (@(posedge clk) !psel |-> !pready)
        else $error("pready high while psel is low");

endmodule

bind ppu_top ppu_assert ppu_assert_i (
    .clk(clk),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .fetch_valid(fetch_valid)
);

// ==== tests/ppu_tb.sv ====
// ----------------------------------------
// PPU testbench
// Random register traffic against a behavioral model,
// display fetch checks under CPU contention
// ----------------------------------------

`timescale 1ns/1ps

module ppu_tb;
    import ppu_pkg::*;

    localparam int WAIT_LIMIT  = 20;
    localparam int FRAME_LIMIT = H_TOTAL * V_TOTAL + 16;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [5:0]  paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    counter_t    h_ctr;
    counter_t    v_ctr;
    logic        fetch_valid;
    vram_addr_t  fetch_addr;
    vram_word_t  fetch_word;

    // Model state
    vram_word_t  vmem [0:32767];
    logic [1:0]  vknown [0:32767];
    vram_addr_t  m_addr;
    logic [7:0]  m_vmain;
    vram_word_t  m_pref;
    color_t      cmem [0:255];
    cgram_addr_t m_cg_addr;
    logic        m_cg_tgl;
    logic [7:0]  m_cg_low;
    logic [15:0] m_m7a;
    logic [7:0]  m_m7b;
    counter_t    m_h;
    counter_t    m_v;
    logic        m_flag;
    logic        m_h_tgl;
    logic        m_v_tgl;
    counter_t    m_hc;
    counter_t    m_vc;

    counter_t    smp_h;
    counter_t    smp_v;
    int          errors;
    int          fetches;
    logic        watch_fetch;

    ppu_top ppu_top_i (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .h_ctr, .v_ctr, .fetch_valid, .fetch_addr, .fetch_word
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    // Left rotate of the low 8, 9 or 10 bits by 3
    function automatic vram_addr_t remap(vram_addr_t a, logic [1:0] mode);
        int         w;
        vram_addr_t mask;
        vram_addr_t low;
        if (mode == 2'd0) begin
            return a;
        end
        w    = 7 + int'(mode);
        mask = vram_addr_t'((1 << w) - 1);
        low  = a & mask;
        return (a & ~mask) | (((low << 3) | (low >> (w - 3))) & mask);
    endfunction

    function automatic vram_addr_t step_size(logic [1:0] mode);
        case (mode)
            2'd0:    return 15'd1;
            2'd1:    return 15'd32;
            default: return 15'd128;
        endcase
    endfunction

    function automatic logic [7:0] expect_read(logic [5:0] idx);
        int p;
        int sa;
        int sb;
        // Two's complement values of the matrix operands
        sa = m_m7a[15] ? int'(m_m7a) - 65536 : int'(m_m7a);
        sb = m_m7b[7] ? int'(m_m7b) - 256 : int'(m_m7b);
        p  = sa * sb;
        case (idx)
            RDVRAML: return m_pref[7:0];
            RDVRAMH: return m_pref[15:8];
            RDCGRAM: return m_cg_tgl ? {1'b0, cmem[m_cg_addr][14:8]} : cmem[m_cg_addr][7:0];
            MPYL:    return p[7:0];
            MPYM:    return p[15:8];
            MPYH:    return p[23:16];
            OPHCT:   return m_h_tgl ? {7'h00, m_h[8]} : m_h[7:0];
            OPVCT:   return m_v_tgl ? {7'h00, m_v[8]} : m_v[7:0];
            STAT78:  return {1'b0, m_flag, 6'h00};
            default: return 8'h00;
        endcase
    endfunction

    task automatic update_model(input logic [5:0] idx, input logic [7:0] d);
        vram_addr_t ra;
        vram_addr_t st;
        logic       inc_hi;
        ra     = remap(m_addr, m_vmain[3:2]);
        st     = step_size(m_vmain[1:0]);
        inc_hi = m_vmain[7];
        case (idx)
            VMAIN: m_vmain = d;
            VMADDL, VMADDH: begin
                if (idx == VMADDL) begin
                    m_addr[7:0] = d;
                end else begin
                    m_addr[14:8] = d[6:0];
                end
                m_pref = vmem[remap(m_addr, m_vmain[3:2])];
            end
            VMDATAL, VMDATAH: begin
                if (idx == VMDATAL) begin
                    vmem[ra][7:0] = d;
                    vknown[ra][0] = 1'b1;
                end else begin
                    vmem[ra][15:8] = d;
                    vknown[ra][1] = 1'b1;
                end
                if (inc_hi == (idx == VMDATAH)) begin
                    m_addr = m_addr + st;
                end
            end
            RDVRAML, RDVRAMH: begin
                if (inc_hi == (idx == RDVRAMH)) begin
                    m_pref = vmem[ra];
                    m_addr = m_addr + st;
                end
            end
            M7A: m_m7a = {d, m_m7a[15:8]};
            M7B: m_m7b = d;
            CGADD: begin
                m_cg_addr = d;
                m_cg_tgl  = 1'b0;
            end
            CGDATA, RDCGRAM: begin
                if (idx == CGDATA && !m_cg_tgl) begin
                    m_cg_low = d;
                end else if (idx == CGDATA) begin
                    cmem[m_cg_addr] = {d[6:0], m_cg_low};
                end
                if (m_cg_tgl) begin
                    m_cg_addr = m_cg_addr + 1'b1;
                end
                m_cg_tgl = !m_cg_tgl;
            end
            SLHV: begin
                m_h    = smp_h;
                m_v    = smp_v;
                m_flag = 1'b1;
            end
            OPHCT: m_h_tgl = !m_h_tgl;
            OPVCT: m_v_tgl = !m_v_tgl;
            STAT78: begin
                m_flag  = 1'b0;
                m_h_tgl = 1'b0;
                m_v_tgl = 1'b0;
            end
            default: ;
        endcase
    endtask

    // Dot and line counts expected during the next cycle
    always @(posedge clk) begin
        if (reset) begin
            m_hc = '0;
            m_vc = '0;
        end else if (m_hc == counter_t'(H_TOTAL - 1)) begin
            m_hc = '0;
            if (m_vc == counter_t'(V_TOTAL - 1)) begin
                m_vc = '0;
            end else begin
                m_vc = m_vc + 1'b1;
            end
        end else begin
            m_hc = m_hc + 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            assert (h_ctr === m_hc) else begin
                $display("mismatch at %0t: h_ctr got %0d expected %0d", $time, h_ctr, m_hc);
                errors++;
            end
            assert (v_ctr === m_vc) else begin
                $display("mismatch at %0t: v_ctr got %0d expected %0d", $time, v_ctr, m_vc);
                errors++;
            end
        end
    end

    // ----------------------------------------
    // APB driver
    // ----------------------------------------

    task automatic apb_transfer(input logic wr, input logic [5:0] idx, input logic [7:0] d,
                                output logic [7:0] rd);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= idx;
        pwdata  <= d;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        assert (pready) else begin
            $display("%0t: access to register %h never saw pready", $time, idx);
            errors++;
        end
        // Counters as the completion edge latches them
        rd    = prdata;
        smp_h = m_hc;
        smp_v = m_vc;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_access(input logic wr, input logic [5:0] idx, input logic [7:0] d);
        logic [7:0] exp;
        logic [7:0] rd;
        exp = expect_read(idx);
        apb_transfer(wr, idx, d, rd);
        if (!wr) begin
            assert (rd === exp) else begin
                $display("mismatch at %0t: prdata (register %h) got %h expected %h",
                         $time, idx, rd, exp);
                errors++;
            end
        end
        update_model(idx, d);
    endtask

    task automatic set_vram_addr(input vram_addr_t a);
        reg_access(1'b1, VMADDL, a[7:0]);
        reg_access(1'b1, VMADDH, {1'b0, a[14:8]});
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %-22s %s (%0d errors)", name, (errors == start) ? "ok" : "failed",
                 errors - start);
    endtask

    // One cycle after each display fetch slot
    always @(negedge clk) begin
        int         dot;
        logic       slot;
        vram_addr_t exp_addr;
        if (watch_fetch) begin
            dot      = int'(m_hc) - 1;
            slot     = dot >= 0 && dot % 8 == 0 && dot < H_VISIBLE && m_vc < V_VISIBLE;
            exp_addr = vram_addr_t'(int'(m_vc) * 32 + dot / 8);
            assert (fetch_valid === slot) else begin
                $display("mismatch at %0t: fetch_valid got %b expected %b",
                         $time, fetch_valid, slot);
                errors++;
            end
            if (fetch_valid) begin
                fetches++;
                assert (fetch_addr === exp_addr) else begin
                    $display("mismatch at %0t: fetch_addr got %h expected %h",
                             $time, fetch_addr, exp_addr);
                    errors++;
                end
                assert (vknown[exp_addr] != 2'b11 || fetch_word === vmem[exp_addr]) else begin
                    $display("mismatch at %0t: fetch_word got %h expected %h",
                             $time, fetch_word, vmem[exp_addr]);
                    errors++;
                end
            end
        end
    end

    // ----------------------------------------
    // Tests
    // ----------------------------------------

    initial begin
        int          r;
        int          i;
        int          n;
        int          start;
        logic [7:0]  vm;
        logic [7:0]  b;
        vram_addr_t  a;
        vram_word_t  w;

        reset       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 6'h00;
        pwdata      = 8'h00;
        errors      = 0;
        fetches     = 0;
        watch_fetch = 1'b0;
        m_addr      = '0;
        m_vmain     = 8'h00;
        m_cg_addr   = '0;
        m_cg_tgl    = 1'b0;
        m_m7a       = 16'h0000;
        m_m7b       = 8'h00;
        m_h         = '0;
        m_v         = '0;
        m_flag      = 1'b0;
        m_h_tgl     = 1'b0;
        m_v_tgl     = 1'b0;
        for (i = 0; i < 32768; i++) begin
            vknown[i] = 2'b00;
        end
        void'($urandom(30));
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        start = errors;
        for (r = 0; r < 8; r++) begin
            vm = 8'($urandom);
            a  = vram_addr_t'($urandom);
            reg_access(1'b1, VMAIN, vm);
            set_vram_addr(a);
            for (i = 0; i < 8; i++) begin
                w = 16'($urandom);
                reg_access(1'b1, vm[7] ? VMDATAL : VMDATAH, vm[7] ? w[7:0] : w[15:8]);
                reg_access(1'b1, vm[7] ? VMDATAH : VMDATAL, vm[7] ? w[15:8] : w[7:0]);
            end
            set_vram_addr(a);
            for (i = 0; i < 8; i++) begin
                reg_access(1'b0, vm[7] ? RDVRAML : RDVRAMH, 8'h00);
                reg_access(1'b0, vm[7] ? RDVRAMH : RDVRAML, 8'h00);
            end
        end
        report_test("vram write and read", start);

        start = errors;
        for (r = 0; r < 4; r++) begin
            b = 8'($urandom);
            reg_access(1'b1, CGADD, b);
            for (i = 0; i < 16; i++) begin
                reg_access(1'b1, CGDATA, 8'($urandom));
            end
            reg_access(1'b1, CGADD, b);
            for (i = 0; i < 16; i++) begin
                reg_access(1'b0, RDCGRAM, 8'h00);
            end
        end
        report_test("cgram", start);

        start = errors;
        for (r = 0; r < 16; r++) begin
            reg_access(1'b1, M7A, 8'($urandom));
            reg_access(1'b1, M7A, 8'($urandom));
            reg_access(1'b1, M7B, 8'($urandom));
            reg_access(1'b0, MPYL, 8'h00);
            reg_access(1'b0, MPYM, 8'h00);
            reg_access(1'b0, MPYH, 8'h00);
        end
        report_test("multiplier", start);

        start = errors;
        for (r = 0; r < 6; r++) begin
            repeat ($urandom_range(400)) @(posedge clk);
            // Last round latches a line count above 255
            if (r == 5) begin
                n = 0;
                while (v_ctr < 9'd256 && n < FRAME_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                assert (n < FRAME_LIMIT) else begin
                    $display("%0t: line counter never reached line 256", $time);
                    errors++;
                end
            end
            reg_access(1'b0, SLHV, 8'h00);
            reg_access(1'b0, OPHCT, 8'h00);
            reg_access(1'b0, OPHCT, 8'h00);
            reg_access(1'b0, OPVCT, 8'h00);
            reg_access(1'b0, OPVCT, 8'h00);
            reg_access(1'b0, STAT78, 8'h00);
            reg_access(1'b0, STAT78, 8'h00);
        end
        report_test("h/v latch", start);

        // Display on with CPU writes aimed a few lines ahead of the fetcher
        start = errors;
        reg_access(1'b1, VMAIN, 8'h80);
        reg_access(1'b1, INIDISP, 8'h00);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(v_ctr == 0 && h_ctr == 0) && n < FRAME_LIMIT);
        assert (n < FRAME_LIMIT) else begin
            $display("%0t: counters never reached the start of a frame", $time);
            errors++;
        end
        watch_fetch = 1'b1;
        for (i = 0; i < 40; i++) begin
            repeat ($urandom_range(40) + 1) @(negedge clk);
            a = vram_addr_t'((int'(v_ctr) + 2 + $urandom_range(3)) * 32 + $urandom_range(31));
            set_vram_addr(a);
            reg_access(1'b1, VMDATAL, 8'($urandom));
            reg_access(1'b1, VMDATAH, 8'($urandom));
        end
        repeat (4 * H_TOTAL) @(posedge clk);
        watch_fetch = 1'b0;
        reg_access(1'b1, INIDISP, 8'h80);
        assert (fetches > 0) else begin
            $display("%0t: no display fetch seen with forced blank off", $time);
            errors++;
        end
        report_test("fetch under contention", start);

        $display("tests 5, errors %0d, fetches checked %0d", errors, fetches);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== list.f ====
verilog/ppu_pkg.sv
verilog/ppu_regs.sv
verilog/vram_port.sv
verilog/vram_bank.sv
verilog/line_fetch.sv
verilog/cgram_port.sv
verilog/ppu_top.sv
tests/ppu_assert.sv
tests/ppu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ppu_tb -f list.f

out=$(./obj_dir/Vppu_tb 2>&1) || true
printf '%s\n' "$out"

# Pass only if the testbench printed the pass line
printf '%s\n' "$out" | grep -Fqx '>>> PASS'
